//--- Makefile
# Verilator flow for the store buffer testbench

TOP := tb_lsu_store_buffer

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f src.f --top-module lsu_store_buffer
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf obj_dir

//--- logic/lsu_store_buffer.sv
// lsu store buffer top: allocator, entry array, drain and forwarding network
`timescale 1ns/1ps
`include "sb_settings.svh"

module lsu_store_buffer (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  input  logic                 valid_i,
  input  sb_pkg::sb_meta_t     meta_i,
  input  sb_pkg::sb_query_t    query_i,
  input  logic                 retire_i,
  input  sb_pkg::dsram_snoop_t snoop_i,
  output logic                 ready_o,
  output sb_pkg::sb_fwd_t      fwd_o,
  output logic                 top_hit_o,
  output sb_pkg::sb_retire_t   cwrite_o
);

  logic             [`SB_DEPTH-1:0] load;
  logic             [`SB_DEPTH-1:0] clear;
  logic             [`SB_PTR_W-1:0] w_ptr;
  logic                             pop;
  logic             [`SB_DEPTH-1:0] entry_valid;
  sb_pkg::sb_meta_t [`SB_DEPTH-1:0] entry_meta;

  sb_alloc i_sb_alloc (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (valid_i),
    .pop_i   (pop),
    .load_o  (load),
    .w_ptr_o (w_ptr),
    .ready_o (ready_o)
  );

  for (genvar i = 0; i < `SB_DEPTH; i++)
  begin : g_entry
    sb_entry i_sb_entry (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .flush_i (flush_i),
      .load_i  (load[i]),
      .clear_i (clear[i]),
      .meta_i  (meta_i),
      .snoop_i (snoop_i),
      .valid_o (entry_valid[i]),
      .meta_o  (entry_meta[i])
    );
  end

  sb_drain i_sb_drain (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .retire_i  (retire_i),
    .valid_i   (entry_valid),
    .meta_i    (entry_meta),
    .clear_o   (clear),
    .pop_o     (pop),
    .top_hit_o (top_hit_o),
    .cwrite_o  (cwrite_o)
  );

  sb_forward i_sb_forward (
    .query_i (query_i),
    .valid_i (entry_valid),
    .meta_i  (entry_meta),
    .w_ptr_i (w_ptr),
    .fwd_o   (fwd_o)
  );

endmodule

//--- logic/sb_alloc.sv
// store buffer allocator: write pointer, occupancy count, full flag and entry load strobes
`timescale 1ns/1ps
`include "sb_settings.svh"

module sb_alloc (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  input  logic                 valid_i,
  input  logic                 pop_i,
  output logic [`SB_DEPTH-1:0] load_o,
  output logic [`SB_PTR_W-1:0] w_ptr_o,
  output logic                 ready_o
);

  localparam int CNT_W = `SB_PTR_W + 1;

  logic [`SB_PTR_W-1:0] w_ptr_q;
  logic [CNT_W-1:0]     cnt_q;
  logic [CNT_W-1:0]     cnt_d;
  logic                 full_q;
  logic                 accept;

  // a push while full is simply lost
  assign accept = valid_i && !full_q;

  always_comb
  begin
    cnt_d = cnt_q;
    if (accept && !pop_i)
      cnt_d = cnt_q + CNT_W'(1);
    else if (!accept && pop_i)
      cnt_d = cnt_q - CNT_W'(1);
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      w_ptr_q <= '0;
      cnt_q   <= '0;
      full_q  <= 1'b0;
    end
    else if (flush_i)
    begin
      w_ptr_q <= '0;
      cnt_q   <= '0;
      full_q  <= 1'b0;
    end
    else
    begin
      if (accept)
        w_ptr_q <= w_ptr_q + `SB_PTR_W'(1);
      cnt_q  <= cnt_d;
      full_q <= (cnt_d == CNT_W'(`SB_DEPTH));
    end
  end

  // one-hot load strobe at the write pointer
  always_comb
  begin
    for (int i = 0; i < `SB_DEPTH; i++)
      load_o[i] = accept && (w_ptr_q == `SB_PTR_W'(i));
  end

  assign w_ptr_o = w_ptr_q;
  assign ready_o = !full_q;

endmodule

//--- logic/sb_drain.sv
// store buffer drain: read pointer, head select, head hit flag and registered retire record
`timescale 1ns/1ps
`include "sb_settings.svh"

module sb_drain (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                flush_i,
  input  logic                                retire_i,
  input  logic             [`SB_DEPTH-1:0]    valid_i,
  input  sb_pkg::sb_meta_t [`SB_DEPTH-1:0]    meta_i,
  output logic             [`SB_DEPTH-1:0]    clear_o,
  output logic                                pop_o,
  output logic                                top_hit_o,
  output sb_pkg::sb_retire_t                  cwrite_o
);

  logic [`SB_PTR_W-1:0] r_ptr_q;
  logic                 head_valid;
  sb_pkg::sb_meta_t     head_meta;
  logic                 fire;

  logic                 rec_valid_q;
  sb_pkg::sb_meta_t     rec_meta_q;
  logic                 rec_hit_q;
  sb_pkg::sb_way_t      rec_way_q;

  // one-hot hit vector to way index
  function automatic sb_pkg::sb_way_t way_of(input sb_pkg::sb_hit_t hit);
    sb_pkg::sb_way_t way;
    way = '0;
    for (int w = 0; w < `SB_WAYS; w++)
      if (hit[w])
        way = way | sb_pkg::sb_way_t'(w);
    return way;
  endfunction

  assign head_valid = valid_i[r_ptr_q];
  assign head_meta  = meta_i[r_ptr_q];

  // retire on an empty head is dropped
  assign fire = retire_i && head_valid;

  always_comb
  begin
    for (int i = 0; i < `SB_DEPTH; i++)
      clear_o[i] = fire && (r_ptr_q == `SB_PTR_W'(i));
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      r_ptr_q     <= '0;
      rec_valid_q <= 1'b0;
    end
    else if (flush_i)
    begin
      r_ptr_q     <= '0;
      rec_valid_q <= 1'b0;
    end
    else
    begin
      if (fire)
        r_ptr_q <= r_ptr_q + `SB_PTR_W'(1);
      rec_valid_q <= fire;
    end
  end

  // record payload, qualified by rec_valid_q
  always_ff @(posedge clk)
  begin
    if (fire)
    begin
      rec_meta_q <= head_meta;
      rec_hit_q  <= |head_meta.hit;
      rec_way_q  <= way_of(head_meta.hit);
    end
  end

  assign pop_o     = fire;
  assign top_hit_o = head_valid && (|head_meta.hit);

  assign cwrite_o = '{valid: rec_valid_q, meta: rec_meta_q, hit: rec_hit_q, way: rec_way_q};

endmodule

//--- logic/sb_entry.sv
// store buffer entry: valid bit, stored store and snoop tracking of its cache hit
`timescale 1ns/1ps
`include "sb_settings.svh"

module sb_entry (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  input  logic                 load_i,
  input  logic                 clear_i,
  input  sb_pkg::sb_meta_t     meta_i,
  input  sb_pkg::dsram_snoop_t snoop_i,
  output logic                 valid_o,
  output sb_pkg::sb_meta_t     meta_o
);

  logic             valid_q;
  sb_pkg::sb_meta_t meta_q;
  sb_pkg::sb_meta_t load_meta;

  // new hit vector after one snoop event
  function automatic sb_pkg::sb_hit_t snoop_hit(
    input sb_pkg::sb_hit_t      hit,
    input sb_pkg::sb_addr_t     addr,
    input sb_pkg::dsram_snoop_t snoop
  );
    logic            line_match;
    sb_pkg::sb_hit_t way_bit;
    line_match = snoop.valid && (snoop.line == addr[29:`SB_LINE_OFS_W]);
    way_bit    = sb_pkg::sb_hit_t'(1) << snoop.way;
    if (!line_match)
      return hit;
    // a fill owns the line in exactly one way
    if (snoop.fill)
      return way_bit;
    return hit & ~way_bit;
  endfunction

  // same-cycle snoop is applied to the incoming store
  always_comb
  begin
    load_meta     = meta_i;
    load_meta.hit = snoop_hit(meta_i.hit, meta_i.addr, snoop_i);
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      valid_q <= 1'b0;
    else if (flush_i || clear_i)
      valid_q <= 1'b0;
    else if (load_i)
      valid_q <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (load_i)
      meta_q <= load_meta;
    else if (valid_q)
      meta_q.hit <= snoop_hit(meta_q.hit, meta_q.addr, snoop_i);
  end

  assign valid_o = valid_q;
  assign meta_o  = meta_q;

endmodule

//--- logic/sb_forward.sv
// store buffer forwarding: age-ordered per-byte merge of matching stores for a load lookup
`timescale 1ns/1ps
`include "sb_settings.svh"

module sb_forward (
  input  sb_pkg::sb_query_t                query_i,
  input  logic             [`SB_DEPTH-1:0] valid_i,
  input  sb_pkg::sb_meta_t [`SB_DEPTH-1:0] meta_i,
  input  logic             [`SB_PTR_W-1:0] w_ptr_i,
  output sb_pkg::sb_fwd_t                  fwd_o
);

  localparam int LANES = $bits(sb_pkg::sb_strb_t);

  // index 0 is the oldest slot, SB_DEPTH-1 the youngest
  logic             [`SB_DEPTH-1:0] age_valid;
  sb_pkg::sb_meta_t [`SB_DEPTH-1:0] age_meta;
  logic             [`SB_DEPTH-1:0] age_match;

  // rotate so that the slot at the write pointer comes first
  for (genvar k = 0; k < `SB_DEPTH; k++)
  begin : g_age
    logic [`SB_PTR_W-1:0] idx;

    assign idx          = w_ptr_i + `SB_PTR_W'(k);
    assign age_valid[k] = valid_i[idx];
    assign age_meta[k]  = meta_i[idx];
    assign age_match[k] = query_i.valid && age_valid[k]
                          && (age_meta[k].addr == query_i.addr);
  end

  // walk oldest to youngest, later matches overwrite the lane
  always_comb
  begin
    fwd_o = '0;
    for (int b = 0; b < LANES; b++)
    begin
      for (int k = 0; k < `SB_DEPTH; k++)
      begin
        if (age_match[k] && age_meta[k].strb[b])
        begin
          fwd_o.data[8*b +: 8] = age_meta[k].data[8*b +: 8];
          fwd_o.mask[b]        = 1'b1;
        end
      end
    end
  end

endmodule

//--- logic/sb_pkg.sv
// store buffer types: address, hit, way, store meta, snoop event, query, forward and retire record
`include "sb_settings.svh"

package sb_pkg;

  // word address of a 32-bit access
  typedef logic [29:0] sb_addr_t;

  // word address without the offset inside the line
  typedef logic [29-`SB_LINE_OFS_W:0] sb_line_t;

  typedef logic [3:0] sb_strb_t;

  // one-hot way vector, zero when the line is not in the cache
  typedef logic [`SB_WAYS-1:0] sb_hit_t;

  typedef logic [$clog2(`SB_WAYS)-1:0] sb_way_t;

  typedef struct packed {
    sb_addr_t    addr;
    logic [31:0] data;
    sb_strb_t    strb;
    sb_hit_t     hit;
  } sb_meta_t;

  // fill or evict from the data SRAM side
  typedef struct packed {
    logic     valid;
    logic     fill;
    sb_line_t line;
    sb_way_t  way;
  } dsram_snoop_t;

  typedef struct packed {
    logic     valid;
    sb_addr_t addr;
  } sb_query_t;

  typedef struct packed {
    logic [31:0] data;
    sb_strb_t    mask;
  } sb_fwd_t;

  typedef struct packed {
    logic     valid;
    sb_meta_t meta;
    logic     hit;
    sb_way_t  way;
  } sb_retire_t;

endpackage

//--- logic/sb_settings.svh
// store buffer sizing macros: depth, pointer width, cache ways, line offset width
`ifndef SB_SETTINGS_SVH
`define SB_SETTINGS_SVH

// number of buffer entries
`define SB_DEPTH 4

// read and write pointer width, log2 of the depth
`define SB_PTR_W 2

// data cache associativity
`define SB_WAYS 2

// word address bits inside a 16-byte line
`define SB_LINE_OFS_W 2

`endif

//--- src.f
+incdir+logic
logic/sb_pkg.sv
logic/sb_alloc.sv
logic/sb_entry.sv
logic/sb_drain.sv
logic/sb_forward.sv
logic/lsu_store_buffer.sv
test/tb_lsu_store_buffer.sv

//--- test/tb_lsu_store_buffer.sv
// testbench for the store buffer: clock, reset, LFSR, queue model, stimulus and assertions
`timescale 1ns/1ps
`include "sb_settings.svh"

module tb_lsu_store_buffer;

  logic                 clk;
  logic                 rst_n_i;
  logic                 flush_i;
  logic                 valid_i;
  sb_pkg::sb_meta_t     meta_i;
  sb_pkg::sb_query_t    query_i;
  logic                 retire_i;
  sb_pkg::dsram_snoop_t snoop_i;
  logic                 ready_o;
  sb_pkg::sb_fwd_t      fwd_o;
  logic                 top_hit_o;
  sb_pkg::sb_retire_t   cwrite_o;

  // values applied at the next rising edge
  logic                 nx_rst_n;
  logic                 nx_flush;
  logic                 nx_valid;
  sb_pkg::sb_meta_t     nx_meta;
  sb_pkg::sb_query_t    nx_query;
  logic                 nx_retire;
  sb_pkg::dsram_snoop_t nx_snoop;

  // reference model with the oldest store at index 0
  sb_pkg::sb_meta_t     mq[$];
  sb_pkg::sb_retire_t   exp_rec;
  logic                 exp_ready;
  logic                 exp_top_hit;
  sb_pkg::sb_fwd_t      exp_fwd;

  logic [31:0]          lfsr;
  int                   value_errors;
  int                   timeouts;

  lsu_store_buffer i_lsu_store_buffer (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .flush_i   (flush_i),
    .valid_i   (valid_i),
    .meta_i    (meta_i),
    .query_i   (query_i),
    .retire_i  (retire_i),
    .snoop_i   (snoop_i),
    .ready_o   (ready_o),
    .fwd_o     (fwd_o),
    .top_hit_o (top_hit_o),
    .cwrite_o  (cwrite_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // outputs are stable at the falling edge
  a_ready: assert property (@(negedge clk) disable iff (!rst_n_i) ready_o == exp_ready)
    else
    begin
      $display("Error ready_o: got %h expected %h", ready_o, exp_ready);
      value_errors++;
    end

  a_top_hit: assert property (@(negedge clk) disable iff (!rst_n_i) top_hit_o == exp_top_hit)
    else
    begin
      $display("Error top_hit_o: got %h expected %h", top_hit_o, exp_top_hit);
      value_errors++;
    end

  a_fwd: assert property (@(negedge clk) disable iff (!rst_n_i) fwd_o == exp_fwd)
    else
    begin
      $display("Error fwd_o: got %h expected %h", fwd_o, exp_fwd);
      value_errors++;
    end

  a_rec_valid: assert property (@(negedge clk) disable iff (!rst_n_i)
                                cwrite_o.valid == exp_rec.valid)
    else
    begin
      $display("Error cwrite_o.valid: got %h expected %h", cwrite_o.valid, exp_rec.valid);
      value_errors++;
    end

  a_rec_body: assert property (@(negedge clk) disable iff (!rst_n_i)
                               !exp_rec.valid || (cwrite_o == exp_rec))
    else
    begin
      $display("Error cwrite_o: got %h expected %h", cwrite_o, exp_rec);
      value_errors++;
    end

  // 32-bit Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic sb_pkg::sb_addr_t rand_addr();
    logic [31:0] r;
    r = rand_bits(30);
    return r[29:0];
  endfunction

  function automatic sb_pkg::sb_meta_t rand_meta(input sb_pkg::sb_addr_t addr,
                                                 input sb_pkg::sb_hit_t  hit);
    sb_pkg::sb_meta_t m;
    logic [31:0]      r;
    m.addr = addr;
    m.data = rand_bits(32);
    r      = rand_bits(4);
    m.strb = r[3:0];
    m.hit  = hit;
    return m;
  endfunction

  function automatic sb_pkg::dsram_snoop_t snoop_ev(input logic             fill,
                                                    input sb_pkg::sb_line_t line,
                                                    input sb_pkg::sb_way_t  way);
    return '{valid: 1'b1, fill: fill, line: line, way: way};
  endfunction

  // a fill owns the line in one way and an evict drops that way only
  function automatic sb_pkg::sb_hit_t snooped(input sb_pkg::sb_hit_t      hit,
                                              input sb_pkg::sb_addr_t     addr,
                                              input sb_pkg::dsram_snoop_t s);
    sb_pkg::sb_hit_t h;
    h = hit;
    if (s.valid && (s.line == addr[29:`SB_LINE_OFS_W]))
    begin
      if (s.fill)
      begin
        h        = '0;
        h[s.way] = 1'b1;
      end
      else
        h[s.way] = 1'b0;
    end
    return h;
  endfunction

  function automatic sb_pkg::sb_way_t way_index(input sb_pkg::sb_hit_t hit);
    sb_pkg::sb_way_t w;
    w = '0;
    for (int i = 0; i < `SB_WAYS; i++)
      if (hit[i])
        w = sb_pkg::sb_way_t'(i);
    return w;
  endfunction

  // inputs still hold the values of the cycle before this edge
  task automatic update_model();
    sb_pkg::sb_meta_t m;
    logic             fire;
    logic             accept;
    if (!rst_n_i || flush_i)
    begin
      mq.delete();
      exp_rec.valid = 1'b0;
      return;
    end
    fire          = retire_i && (mq.size() > 0);
    accept        = valid_i && (mq.size() < `SB_DEPTH);
    exp_rec.valid = fire;
    if (fire)
    begin
      m            = mq.pop_front();
      exp_rec.meta = m;
      exp_rec.hit  = |m.hit;
      exp_rec.way  = way_index(m.hit);
    end
    for (int i = 0; i < mq.size(); i++)
    begin
      m     = mq[i];
      m.hit = snooped(m.hit, m.addr, snoop_i);
      mq[i] = m;
    end
    if (accept)
    begin
      m     = meta_i;
      m.hit = snooped(m.hit, m.addr, snoop_i);
      mq.push_back(m);
    end
  endtask

  task automatic compute_expect();
    exp_ready   = (mq.size() < `SB_DEPTH);
    exp_top_hit = 1'b0;
    if (mq.size() > 0)
      exp_top_hit = |mq[0].hit;
    // younger stores overwrite older ones lane by lane
    exp_fwd = '0;
    if (nx_query.valid)
      for (int i = 0; i < mq.size(); i++)
        for (int b = 0; b < 4; b++)
          if ((mq[i].addr == nx_query.addr) && mq[i].strb[b])
          begin
            exp_fwd.data[8*b +: 8] = mq[i].data[8*b +: 8];
            exp_fwd.mask[b]        = 1'b1;
          end
  endtask

  task automatic step();
    @(posedge clk);
    update_model();
    rst_n_i  <= nx_rst_n;
    flush_i  <= nx_flush;
    valid_i  <= nx_valid;
    meta_i   <= nx_meta;
    query_i  <= nx_query;
    retire_i <= nx_retire;
    snoop_i  <= nx_snoop;
    compute_expect();
    nx_flush  = 1'b0;
    nx_valid  = 1'b0;
    nx_retire = 1'b0;
    nx_snoop  = '0;
  endtask

  task automatic push(input sb_pkg::sb_meta_t m);
    nx_valid = 1'b1;
    nx_meta  = m;
    step();
  endtask

  task automatic wait_ready(input logic level);
    int n;
    n = 0;
    // the model has to follow every edge
    step();
    @(negedge clk);
    while ((ready_o !== level) && (n < 16))
    begin
      step();
      @(negedge clk);
      n++;
    end
    if (ready_o !== level)
    begin
      $display("Timeout: ready_o never reached %0d", level);
      timeouts++;
    end
  endtask

  task automatic retire_one();
    int n;
    n         = 0;
    nx_retire = 1'b1;
    step();
    @(negedge clk);
    while (!cwrite_o.valid && (n < 8))
    begin
      step();
      @(negedge clk);
      n++;
    end
    if (!cwrite_o.valid)
    begin
      $display("Timeout: no retire record appeared after a retire");
      timeouts++;
    end
  endtask

  initial
  begin
    sb_pkg::sb_meta_t m;
    sb_pkg::sb_addr_t a;
    lfsr         = 32'hfa36_a348;
    value_errors = 0;
    timeouts     = 0;
    rst_n_i      = 1'b0;
    flush_i      = 1'b0;
    valid_i      = 1'b0;
    meta_i       = '0;
    query_i      = '0;
    retire_i     = 1'b0;
    snoop_i      = '0;
    nx_rst_n     = 1'b0;
    nx_flush     = 1'b0;
    nx_valid     = 1'b0;
    nx_meta      = '0;
    nx_query     = '0;
    nx_retire    = 1'b0;
    nx_snoop     = '0;
    exp_rec      = '0;
    exp_ready    = 1'b1;
    exp_top_hit  = 1'b0;
    exp_fwd      = '0;

    repeat (16) step();
    nx_rst_n = 1'b1;
    step();
    wait_ready(1'b1);
    nx_retire = 1'b1;
    step();
    step();

    // capacity with a fifth push that is lost
    a = rand_addr();
    nx_query = '{valid: 1'b1, addr: a};
    push(rand_meta(a, '0));
    for (int i = 0; i < 4; i++)
      push(rand_meta(rand_addr(), '0));
    wait_ready(1'b0);
    retire_one();
    wait_ready(1'b1);
    repeat (3) retire_one();

    // overlapping stores to one word
    a = rand_addr();
    m = rand_meta(a, '0);
    m.strb = 4'b0011;
    push(m);
    m = rand_meta(a, '0);
    m.strb = 4'b0110;
    push(m);
    m = rand_meta(a ^ 30'h1, '0);
    m.strb = 4'b1111;
    push(m);
    nx_query = '{valid: 1'b1, addr: a};
    step();
    nx_query.addr = a ^ 30'h4;
    step();
    nx_query.addr = a;
    repeat (3) retire_one();
    nx_query.valid = 1'b0;

    // fill after the push and then in the push cycle
    a = rand_addr();
    push(rand_meta(a, '0));
    nx_snoop = snoop_ev(1'b1, a[29:`SB_LINE_OFS_W], 1'b1);
    step();
    retire_one();
    nx_snoop = snoop_ev(1'b1, a[29:`SB_LINE_OFS_W], 1'b1);
    push(rand_meta(a, '0));
    retire_one();

    // evicts of another line and way before the owning way
    push(rand_meta(a, 2'b10));
    nx_snoop = snoop_ev(1'b0, a[29:`SB_LINE_OFS_W] ^ sb_pkg::sb_line_t'(1), 1'b1);
    step();
    nx_snoop = snoop_ev(1'b0, a[29:`SB_LINE_OFS_W], 1'b0);
    step();
    nx_snoop = snoop_ev(1'b0, a[29:`SB_LINE_OFS_W], 1'b1);
    step();
    retire_one();

    // push with retire below full and at full
    push(rand_meta(rand_addr(), '0));
    push(rand_meta(rand_addr(), '0));
    for (int i = 0; i < 2; i++)
    begin
      nx_retire = 1'b1;
      push(rand_meta(rand_addr(), '0));
    end
    push(rand_meta(rand_addr(), '0));
    push(rand_meta(rand_addr(), '0));
    wait_ready(1'b0);
    nx_retire = 1'b1;
    push(rand_meta(rand_addr(), '0));
    repeat (3) retire_one();

    // flush of a partly filled buffer under a matching lookup
    a = rand_addr();
    m = rand_meta(a, 2'b01);
    m.strb = 4'b1111;
    nx_query = '{valid: 1'b1, addr: a};
    push(m);
    push(rand_meta(rand_addr(), '0));
    nx_flush = 1'b1;
    step();
    wait_ready(1'b1);
    nx_retire = 1'b1;
    step();
    repeat (3) step();
    @(posedge clk);

    $display("errors: %0d value, %0d timeout", value_errors, timeouts);
    if ((value_errors == 0) && (timeouts == 0))
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
